// ==== hw/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

  // line and instruction geometry
  localparam int LINE_BYTES  = 64;
  localparam int INSTR_BYTES = 4;
  localparam int PC_W        = 64;

  localparam int LINE_W    = LINE_BYTES * 8;                      // 512 bit line
  localparam int OFF_W     = $clog2(LINE_BYTES);                  // byte offset in a line
  localparam int WORD_W    = $clog2(LINE_BYTES / INSTR_BYTES);    // word index in a line
  localparam int WIN_SLOTS = 4;                                   // instructions per fetch window

  // opcode match values, compared against the top bits of an instruction
  localparam logic [5:0]  OPC_B     = 6'b000101;        // b imm26
  localparam logic [5:0]  OPC_BL    = 6'b100101;        // bl imm26
  localparam logic [10:0] OPC_RET   = 11'b11010110010;  // ret xn
  localparam logic [7:0]  OPC_BCOND = 8'b01010100;      // b.cond imm19

  // what the predecoder found in a window
  typedef enum logic [2:0] {
    BR_NONE,
    BR_B,
    BR_BL,
    BR_RET,
    BR_COND
  } br_kind_e;

  // fetch sequencing
  typedef enum logic [1:0] {
    FS_ISSUE,   // l1 request goes out
    FS_WAIT,    // waiting on the l1 line
    FS_DROP,    // outstanding line is stale, throw it away
    FS_STREAM   // next window comes from l0
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== hw/return_stack.sv ====
`timescale 1ns/1ns
`default_nettype none

module return_stack #(
  parameter int DEPTH = 8
) (
  input  wire                     clk_in,
  input  wire                     rst_N_in,
  input  wire                     push,
  input  wire                     pop,
  input  wire [bp_pkg::PC_W-1:0]  push_addr,
  output logic [bp_pkg::PC_W-1:0] top
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [bp_pkg::PC_W-1:0] entries [DEPTH];
  logic [PTR_W-1:0]        ptr;     // points at the current top
  logic [PTR_W-1:0]        ptr_up;
  logic [PTR_W-1:0]        ptr_dn;

  // wrap both ways, overflow just overwrites the oldest entry
  assign ptr_up = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  assign ptr_dn = (ptr == '0) ? PTR_W'(DEPTH - 1) : ptr - 1'b1;

  assign top = entries[ptr];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ptr <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        entries[i] <= '0;  // empty stack reads back zero
      end
    end else if (push) begin
      entries[ptr_up] <= push_addr;  // write above the old top
      ptr             <= ptr_up;
    end else if (pop) begin
      ptr <= ptr_dn;  // empty pop simply wraps
    end
  end

endmodule

`default_nettype wire

// ==== hw/gshare_pht.sv ====
`timescale 1ns/1ns
`default_nettype none

module gshare_pht #(
  parameter int GHR_BITS = 8,
  parameter int PC_BITS  = 8
) (
  input  wire                    clk_in,
  input  wire                    rst_N_in,
  input  wire [bp_pkg::PC_W-1:0] pred_pc,
  input  wire                    upd_valid,
  input  wire [bp_pkg::PC_W-1:0] upd_pc,
  input  wire                    upd_taken,
  output logic                   pred_taken
);

  localparam int IDX_W   = GHR_BITS + PC_BITS;
  localparam int ENTRIES = 1 << IDX_W;

  logic [1:0]          pht [ENTRIES];  // 2-bit saturating counters
  logic [GHR_BITS-1:0] ghr;            // newest outcome in bit 0
  logic [IDX_W-1:0]    pred_idx;
  logic [IDX_W-1:0]    upd_idx;
  logic [1:0]          upd_ctr;

  // history on top, word address below
  assign pred_idx = {ghr, pred_pc[PC_BITS+1:2]};
  assign upd_idx  = {ghr, upd_pc[PC_BITS+1:2]};  // ghr before this update's shift

  assign pred_taken = (pht[pred_idx] >= 2'd2);   // weakly or strongly taken
  assign upd_ctr    = pht[upd_idx];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ghr <= '0;
      for (int i = 0; i < ENTRIES; i++) begin
        pht[i] <= 2'd0;  // strongly not taken
      end
    end else if (upd_valid) begin
      if (upd_taken && (upd_ctr != 2'd3)) begin
        pht[upd_idx] <= upd_ctr + 2'd1;
      end else if (!upd_taken && (upd_ctr != 2'd0)) begin
        pht[upd_idx] <= upd_ctr - 2'd1;
      end
      ghr <= {ghr[GHR_BITS-2:0], upd_taken};  // shift outcome in
    end
  end

endmodule

`default_nettype wire

// ==== hw/l0_icache.sv ====
`timescale 1ns/1ns
`default_nettype none

module l0_icache #(
  parameter int SETS = 8
) (
  input  wire                       clk_in,
  input  wire                       rst_N_in,
  input  wire                       fill_valid,
  input  wire [bp_pkg::PC_W-1:0]    fill_addr,
  input  wire [bp_pkg::LINE_W-1:0]  fill_line,
  input  wire [bp_pkg::PC_W-1:0]    look_addr,
  output logic                      hit,
  output logic [bp_pkg::LINE_W-1:0] line
);

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = bp_pkg::PC_W - bp_pkg::OFF_W - IDX_W;

  logic [bp_pkg::LINE_W-1:0] data [SETS];
  logic [TAG_W-1:0]          tags [SETS];
  logic [SETS-1:0]           valid;

  logic [IDX_W-1:0] fill_idx;
  logic [TAG_W-1:0] fill_tag;
  logic [IDX_W-1:0] look_idx;
  logic [TAG_W-1:0] look_tag;

  // set index sits right above the byte offset
  assign fill_idx = fill_addr[bp_pkg::OFF_W +: IDX_W];
  assign fill_tag = fill_addr[bp_pkg::PC_W-1 -: TAG_W];
  assign look_idx = look_addr[bp_pkg::OFF_W +: IDX_W];
  assign look_tag = look_addr[bp_pkg::PC_W-1 -: TAG_W];

  // lookup is purely combinational
  assign hit  = valid[look_idx] && (tags[look_idx] == look_tag);
  assign line = data[look_idx];  // only meaningful with hit

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      valid <= '0;  // cache starts empty
    end else if (fill_valid) begin
      valid[fill_idx] <= 1'b1;
    end
  end

  // line and tag storage
  always_ff @(posedge clk_in) begin
    if (fill_valid) begin
      data[fill_idx] <= fill_line;  // a fill always replaces the set
      tags[fill_idx] <= fill_tag;
    end
  end

endmodule

`default_nettype wire

// ==== hw/predecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module predecode (
  input  wire [bp_pkg::PC_W-1:0]   pc,
  input  wire [bp_pkg::LINE_W-1:0] line,
  input  wire [bp_pkg::PC_W-1:0]   ras_top,
  input  wire                      cond_taken,
  output logic                     br_valid,
  output logic [1:0]               br_slot,
  output bp_pkg::br_kind_e         br_kind,
  output logic [bp_pkg::PC_W-1:0]  br_target,
  output logic                     br_taken,
  output logic [bp_pkg::PC_W-1:0]  next_pc,
  output logic                     ras_push,
  output logic                     ras_pop,
  output logic [bp_pkg::PC_W-1:0]  push_addr
);

  localparam int IDX_W = bp_pkg::WORD_W + 1;  // msb flags a slot past the line end

  logic [IDX_W-1:0]        word_idx;
  logic [31:0]             instr;
  logic [bp_pkg::PC_W-1:0] slot_pc;
  logic [bp_pkg::PC_W-1:0] imm26_off;
  logic [bp_pkg::PC_W-1:0] imm19_off;
  logic                    done;       // window already ended by a taken branch
  logic                    cond_seen;  // first b.cond already passed
  logic [2:0]              n_slots;    // slots inside the window

  always_comb begin
    br_valid  = 1'b0;
    br_slot   = 2'd0;
    br_kind   = bp_pkg::BR_NONE;
    br_target = '0;
    br_taken  = 1'b0;
    ras_push  = 1'b0;
    ras_pop   = 1'b0;
    push_addr = '0;
    done      = 1'b0;
    cond_seen = 1'b0;
    n_slots   = 3'd0;

    for (int i = 0; i < bp_pkg::WIN_SLOTS; i++) begin
      word_idx  = {1'b0, pc[bp_pkg::OFF_W-1:2]} + IDX_W'(i);
      slot_pc   = pc + bp_pkg::PC_W'(bp_pkg::INSTR_BYTES * i);
      instr     = line[32*word_idx[bp_pkg::WORD_W-1:0] +: 32];
      imm26_off = {{36{instr[25]}}, instr[25:0], 2'b00};  // sign-extended, word scaled
      imm19_off = {{43{instr[23]}}, instr[23:5], 2'b00};

      if (!word_idx[IDX_W-1] && !done) begin  // still inside line and window
        n_slots = 3'(i + 1);
        if ((instr[31:26] == bp_pkg::OPC_B) || (instr[31:26] == bp_pkg::OPC_BL)) begin
          br_valid  = 1'b1;
          br_slot   = 2'(i);
          br_target = slot_pc + imm26_off;
          br_taken  = 1'b1;
          done      = 1'b1;
          if (instr[31:26] == bp_pkg::OPC_BL) begin
            br_kind   = bp_pkg::BR_BL;
            ras_push  = 1'b1;
            push_addr = slot_pc + bp_pkg::PC_W'(bp_pkg::INSTR_BYTES);  // return address
          end else begin
            br_kind = bp_pkg::BR_B;
          end
        end else if (instr[31:21] == bp_pkg::OPC_RET) begin
          br_valid  = 1'b1;
          br_slot   = 2'(i);
          br_kind   = bp_pkg::BR_RET;
          br_target = ras_top;  // predicted return
          br_taken  = 1'b1;
          ras_pop   = 1'b1;
          done      = 1'b1;
        end else if (instr[31:24] == bp_pkg::OPC_BCOND) begin
          // only the first b.cond has a gshare lookup, later ones fall through
          br_valid  = 1'b1;
          br_slot   = 2'(i);
          br_kind   = bp_pkg::BR_COND;
          br_target = slot_pc + imm19_off;
          br_taken  = !cond_seen && cond_taken;
          done      = br_taken;  // a not-taken b.cond keeps scanning
          cond_seen = 1'b1;
        end
      end
    end

    // sequential successor when nothing redirects
    if (br_taken) begin
      next_pc = br_target;
    end else begin
      next_pc = pc + bp_pkg::PC_W'(bp_pkg::INSTR_BYTES * n_slots);
    end
  end

endmodule

`default_nettype wire

// ==== hw/branch_pred.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_pred #(
  parameter int L0_SETS   = 8,
  parameter int RAS_DEPTH = 8,
  parameter int GHR_BITS  = 8,
  parameter int PC_BITS   = 8
) (
  input  wire                       clk_in,
  input  wire                       rst_N_in,
  input  wire                       l1i_valid,
  input  wire [bp_pkg::LINE_W-1:0]  l1i_line,
  input  wire                       x_bcond_resolved,
  input  wire                       x_taken,
  input  wire                       x_pc_incorrect,
  input  wire [bp_pkg::PC_W-1:0]    x_pc,
  input  wire [18:0]                x_correction_offset,
  output logic                      l1i_req,
  output logic [bp_pkg::PC_W-1:0]   l1i_addr,
  output logic                      pc_valid_out,
  output logic [bp_pkg::PC_W-1:0]   fetch_pc,
  output logic [bp_pkg::LINE_W-1:0] fetch_line,
  output logic [bp_pkg::PC_W-1:0]   pred_pc,
  output logic                      br_valid,
  output logic [1:0]                br_slot,
  output bp_pkg::br_kind_e          br_kind,
  output logic [bp_pkg::PC_W-1:0]   br_target,
  output logic                      br_taken,
  output logic                      l0_next_hit
);

  localparam int IDX_W = bp_pkg::WORD_W + 1;

  bp_pkg::fetch_state_e state;
  bp_pkg::fetch_state_e state_d;

  logic [bp_pkg::PC_W-1:0]   pc_q;         // pc of the next window
  logic [bp_pkg::PC_W-1:0]   pc_d;
  logic [bp_pkg::PC_W-1:0]   redirect_pc;
  logic                      outstanding;  // l1 request in flight past this cycle
  logic                      eval;         // a window is predecoded this cycle
  logic                      accept;       // ...and not killed by a redirect
  logic                      fill_valid;
  logic                      l0_hit;
  logic [bp_pkg::LINE_W-1:0] l0_line;
  logic [bp_pkg::LINE_W-1:0] win_line;

  logic [bp_pkg::PC_W-1:0] ras_top;
  logic                    ras_push;
  logic                    ras_pop;
  logic [bp_pkg::PC_W-1:0] cond_pc;      // first b.cond slot, feeds gshare
  logic                    cond_taken;
  logic [IDX_W-1:0]        scan_idx;
  logic [31:0]             scan_word;

  logic                    pd_br_valid;
  logic [1:0]              pd_br_slot;
  bp_pkg::br_kind_e        pd_br_kind;
  logic [bp_pkg::PC_W-1:0] pd_br_target;
  logic                    pd_br_taken;
  logic [bp_pkg::PC_W-1:0] pd_next_pc;
  logic                    pd_ras_push;
  logic                    pd_ras_pop;
  logic [bp_pkg::PC_W-1:0] pd_push_addr;

  assign redirect_pc = x_pc + {{45{x_correction_offset[18]}}, x_correction_offset};
  assign l1i_addr    = {pc_q[bp_pkg::PC_W-1:bp_pkg::OFF_W], {bp_pkg::OFF_W{1'b0}}};

  assign eval = ((state == bp_pkg::FS_WAIT) && l1i_valid)
             || ((state == bp_pkg::FS_STREAM) && l0_hit);
  assign accept     = eval && !x_pc_incorrect;
  assign win_line   = (state == bp_pkg::FS_WAIT) ? l1i_line : l0_line;
  assign fill_valid = l1i_valid && (state == bp_pkg::FS_WAIT);  // drop state never fills

  // stack moves only for windows that reach the output
  assign ras_push = accept && pd_ras_push;
  assign ras_pop  = accept && pd_ras_pop;

  // successor is in l0 when the lookup of pred_pc hits during its output cycle
  assign l0_next_hit = pc_valid_out && l0_hit;

  // first b.cond of the window, scanned backwards so the lowest slot wins
  always_comb begin
    cond_pc = pc_q;  // unused when the window has no b.cond
    for (int i = bp_pkg::WIN_SLOTS - 1; i >= 0; i--) begin
      scan_idx  = {1'b0, pc_q[bp_pkg::OFF_W-1:2]} + IDX_W'(i);
      scan_word = win_line[32*scan_idx[bp_pkg::WORD_W-1:0] +: 32];
      if (!scan_idx[IDX_W-1] && (scan_word[31:24] == bp_pkg::OPC_BCOND)) begin
        cond_pc = pc_q + bp_pkg::PC_W'(bp_pkg::INSTR_BYTES * i);
      end
    end
  end

  // fsm next state
  always_comb begin
    outstanding = 1'b0;
    state_d     = state;
    case (state)
      bp_pkg::FS_ISSUE: begin
        outstanding = l1i_req;  // the request leaves in this cycle
        if (l1i_req) begin
          state_d = bp_pkg::FS_WAIT;
        end
      end
      bp_pkg::FS_WAIT, bp_pkg::FS_DROP: begin
        outstanding = !l1i_valid;
        if (l1i_valid) begin
          state_d = bp_pkg::FS_STREAM;  // next pc goes to l0 first
        end
      end
      bp_pkg::FS_STREAM: begin
        if (!l0_hit) begin
          state_d = bp_pkg::FS_ISSUE;  // l0 miss
        end
      end
      default: state_d = bp_pkg::FS_ISSUE;
    endcase
    if (x_pc_incorrect) begin
      if (outstanding) begin
        state_d = bp_pkg::FS_DROP;  // returning line belongs to the old path
      end else begin
        state_d = bp_pkg::FS_STREAM;
      end
    end
  end

  always_comb begin
    if (x_pc_incorrect) begin
      pc_d = redirect_pc;
    end else if (accept) begin
      pc_d = pd_next_pc;
    end else begin
      pc_d = pc_q;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      state        <= bp_pkg::FS_ISSUE;
      pc_q         <= '0;
      l1i_req      <= 1'b0;  // first request goes out one cycle after reset
      pc_valid_out <= 1'b0;
      br_valid     <= 1'b0;
    end else begin
      state        <= state_d;
      pc_q         <= pc_d;
      l1i_req      <= (state_d == bp_pkg::FS_ISSUE);
      pc_valid_out <= accept;
      br_valid     <= accept && pd_br_valid;
    end
  end

  // window payload, held between windows
  always_ff @(posedge clk_in) begin
    if (accept) begin
      fetch_pc   <= pc_q;
      fetch_line <= win_line;
      pred_pc    <= pd_next_pc;
      br_slot    <= pd_br_slot;
      br_kind    <= pd_br_kind;
      br_target  <= pd_br_target;
      br_taken   <= pd_br_taken;
    end
  end

  return_stack #(
    .DEPTH(RAS_DEPTH)
  ) u_ras (
    .clk_in    (clk_in),
    .rst_N_in  (rst_N_in),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (pd_push_addr),
    .top       (ras_top)
  );

  gshare_pht #(
    .GHR_BITS(GHR_BITS),
    .PC_BITS (PC_BITS)
  ) u_pht (
    .clk_in     (clk_in),
    .rst_N_in   (rst_N_in),
    .pred_pc    (cond_pc),
    .upd_valid  (x_bcond_resolved),
    .upd_pc     (x_pc),
    .upd_taken  (x_taken),
    .pred_taken (cond_taken)
  );

  l0_icache #(
    .SETS(L0_SETS)
  ) u_l0 (
    .clk_in     (clk_in),
    .rst_N_in   (rst_N_in),
    .fill_valid (fill_valid),
    .fill_addr  (pc_q),  // still the requested pc while waiting
    .fill_line  (l1i_line),
    .look_addr  (pc_q),
    .hit        (l0_hit),
    .line       (l0_line)
  );

  predecode u_pd (
    .pc         (pc_q),
    .line       (win_line),
    .ras_top    (ras_top),
    .cond_taken (cond_taken),
    .br_valid   (pd_br_valid),
    .br_slot    (pd_br_slot),
    .br_kind    (pd_br_kind),
    .br_target  (pd_br_target),
    .br_taken   (pd_br_taken),
    .next_pc    (pd_next_pc),
    .ras_push   (pd_ras_push),
    .ras_pop    (pd_ras_pop),
    .push_addr  (pd_push_addr)
  );

endmodule

`default_nettype wire

// ==== verification/bp_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_assert (
  input wire        clk_in,
  input wire        rst_N_in,
  input wire        l1i_req,
  input wire        l1i_valid,
  input wire        pc_valid_out,
  input wire        br_valid,
  input wire [1:0]  br_slot,
  input wire [63:0] fetch_pc
);

  logic busy;  // a request left and its line has not come back
  int   fail_count = 0;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) busy <= 1'b0;
    else if (l1i_valid) busy <= 1'b0;
    else if (l1i_req) busy <= 1'b1;
  end

  a_single_req: assert property (@(posedge clk_in) disable iff (rst_N_in)
    l1i_req |-> !busy)
    else begin
      $error("l1i_req pulsed while a request was outstanding");
      fail_count++;
    end

  a_quiet_after_reset: assert property (@(posedge clk_in)
    $fell(rst_N_in) |-> (!pc_valid_out && !l1i_req))
    else begin
      $error("pc_valid_out or l1i_req high in the first cycle after reset");
      fail_count++;
    end

  // reported slot must lie before the line end
  a_slot_in_line: assert property (@(posedge clk_in) disable iff (rst_N_in)
    br_valid |-> (({1'b0, fetch_pc[5:2]} + {3'b0, br_slot}) < 5'd16))
    else begin
      $error("br_slot lies past the end of the fetch line");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== verification/bp_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_checker #(
  parameter int L0_SETS   = 8,
  parameter int RAS_DEPTH = 8,
  parameter int GHR_BITS  = 8,
  parameter int PC_BITS   = 8
) (
  input  wire                      clk_in,
  input  wire                      rst_N_in,
  input  wire [31:0]               test_idx,
  input  wire                      l1i_req,
  input  wire [63:0]               l1i_addr,
  input  wire                      l1i_valid,
  input  wire [511:0]              l1i_line,
  input  wire                      x_bcond_resolved,
  input  wire                      x_taken,
  input  wire                      x_pc_incorrect,
  input  wire [63:0]               x_pc,
  input  wire [18:0]               x_correction_offset,
  input  wire                      pc_valid_out,
  input  wire [63:0]               fetch_pc,
  input  wire [511:0]              fetch_line,
  input  wire [63:0]               pred_pc,
  input  wire                      br_valid,
  input  wire [1:0]                br_slot,
  input  wire bp_pkg::br_kind_e    br_kind,
  input  wire [63:0]               br_target,
  input  wire                      br_taken,
  input  wire                      l0_next_hit,
  output logic [31:0]              total_errors,
  output logic [31:0]              total_windows
);

  localparam int PHT_N = 1 << (GHR_BITS + PC_BITS);

  logic [1:0]          m_pht [PHT_N];
  logic [GHR_BITS-1:0] m_ghr;
  logic [63:0]         m_ras [RAS_DEPTH];
  int                  m_ptr;
  logic                m_val [L0_SETS];
  logic [57:0]         m_tag [L0_SETS];  // full line number
  logic [511:0]        m_line [L0_SETS];

  logic [63:0]  exp_pc;     // where the next window must start
  logic [63:0]  req_addr;
  logic [63:0]  res_pc;
  logic         outst, drop_pend, dropped, redir_q, res_pend, res_taken;
  logic [511:0] ln;
  logic         e_valid, e_taken;
  logic [1:0]   e_slot;
  bp_pkg::br_kind_e e_kind;
  logic [63:0]  e_target, e_next, e_push;
  int           e_stack;    // +1 push, -1 pop
  int           test_err, test_win, cur_test;

  initial begin
    total_errors = 0;
    total_windows = 0;
    cur_test = 0;
  end

  function automatic int set_of(input logic [63:0] a);
    return int'(a[63:6] % L0_SETS);
  endfunction

  function automatic logic l0_has(input logic [63:0] a);
    return m_val[set_of(a)] && (m_tag[set_of(a)] == a[63:6]);
  endfunction

  task automatic report(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    test_err++;
    total_errors++;
  endtask

  task automatic check(input string name, input logic [511:0] expv, input logic [511:0] act);
    if (expv !== act) begin
      $display("FAILED %0t %s expected %0h got %0h", $time, name, expv, act);
      test_err++;
      total_errors++;
    end
  endtask

  // window rules: first b/bl/ret or predicted-taken b.cond ends the scan
  task automatic predict(input logic [63:0] pc, input logic [511:0] lin);
    logic [31:0] w;
    logic [63:0] spc;
    int          off, n;
    logic        done, cond_seen;
    e_valid = 0; e_taken = 0; e_slot = 0; e_kind = bp_pkg::BR_NONE;
    e_target = '0; e_push = '0; e_stack = 0;
    done = 0; cond_seen = 0; n = 0;
    for (int i = 0; i < 4; i++) begin
      off = int'(pc[5:0]) + 4 * i;
      if (off < bp_pkg::LINE_BYTES && !done) begin  // stop at the line end
        w   = lin[off*8 +: 32];
        spc = pc + 64'(4 * i);
        n   = i + 1;
        if (w[31:26] == bp_pkg::OPC_B || w[31:26] == bp_pkg::OPC_BL) begin
          e_valid = 1; e_slot = 2'(i); e_taken = 1; done = 1;
          e_target = spc + ({{38{w[25]}}, w[25:0]} << 2);
          e_kind = (w[31:26] == bp_pkg::OPC_BL) ? bp_pkg::BR_BL : bp_pkg::BR_B;
          if (e_kind == bp_pkg::BR_BL) begin
            e_stack = 1;
            e_push  = spc + 64'd4;  // return address
          end
        end else if (w[31:21] == bp_pkg::OPC_RET) begin
          e_valid = 1; e_slot = 2'(i); e_taken = 1; done = 1;
          e_kind = bp_pkg::BR_RET;
          e_target = m_ras[m_ptr];
          e_stack = -1;
        end else if (w[31:24] == bp_pkg::OPC_BCOND) begin
          e_valid = 1; e_slot = 2'(i); e_kind = bp_pkg::BR_COND;
          e_target = spc + ({{45{w[23]}}, w[23:5]} << 2);
          e_taken = !cond_seen && (m_pht[{m_ghr, spc[PC_BITS+1:2]}] >= 2'd2);
          done = e_taken;
          cond_seen = 1;  // only the first b.cond gets a lookup
        end
      end
    end
    e_next = e_taken ? e_target : pc + 64'(4 * n);
  endtask

  task automatic train(input logic [63:0] pc, input logic tk);
    logic [GHR_BITS+PC_BITS-1:0] idx;
    idx = {m_ghr, pc[PC_BITS+1:2]};  // history from before the shift
    if (tk && m_pht[idx] != 2'd3) m_pht[idx] = m_pht[idx] + 2'd1;
    if (!tk && m_pht[idx] != 2'd0) m_pht[idx] = m_pht[idx] - 2'd1;
    m_ghr = {m_ghr[GHR_BITS-2:0], tk};
  endtask

  always @(posedge clk_in) begin
    if (test_idx != cur_test) begin
      if (cur_test >= 1 && cur_test <= 5)
        $display("test %0d %s: %0d windows, %0d errors", cur_test,
                 (cur_test == 1) ? "straight_line" : (cur_test == 2) ? "branch_ras" :
                 (cur_test == 3) ? "gshare" : (cur_test == 4) ? "l0_stream" : "redirect",
                 test_win, test_err);
      cur_test = test_idx;
      test_err = 0;
      test_win = 0;
    end
    if (rst_N_in) begin
      for (int i = 0; i < PHT_N; i++) m_pht[i] = 2'd0;
      for (int i = 0; i < RAS_DEPTH; i++) m_ras[i] = '0;
      for (int i = 0; i < L0_SETS; i++) m_val[i] = 1'b0;
      m_ghr = '0; m_ptr = 0; exp_pc = '0;
      outst = 0; drop_pend = 0; dropped = 0; redir_q = 0; res_pend = 0;
    end else begin
      // window evaluated last cycle, against state from then
      if (pc_valid_out) begin
        test_win++;
        total_windows++;
        if (redir_q) report("window output although a redirect hit its evaluation cycle");
        if (dropped) report("window output for a discarded L1 line");
        check("fetch_pc", exp_pc, fetch_pc);
        if (!l0_has(exp_pc)) begin
          report("window line was never filled into the model L0");
          exp_pc = pred_pc;  // resync
        end else begin
          ln = m_line[set_of(exp_pc)];
          predict(exp_pc, ln);
          check("fetch_line", ln, fetch_line);
          check("br_valid", e_valid, br_valid);
          check("br_kind", e_kind, br_kind);
          check("br_taken", e_taken, br_taken);
          check("pred_pc", e_next, pred_pc);
          if (e_valid) begin
            check("br_slot", e_slot, br_slot);
            check("br_target", e_target, br_target);
          end
          if (cur_test == 1 && br_valid) report("branch reported in straight-line code");
          if (e_stack == 1) begin
            m_ptr = (m_ptr + 1) % RAS_DEPTH;  // overflow overwrites the oldest
            m_ras[m_ptr] = e_push;
          end else if (e_stack == -1) begin
            m_ptr = (m_ptr + RAS_DEPTH - 1) % RAS_DEPTH;
          end
          exp_pc = e_next;
          check("l0_next_hit", l0_has(e_next), l0_next_hit);
        end
      end else if (l0_next_hit) begin
        report("l0_next_hit raised without a window");
      end
      if (l1i_req) begin
        if (outst) report("second L1 request while one is outstanding");
        if (l0_has(exp_pc)) report("L1 request for a line already in L0");
        check("l1i_addr", {exp_pc[63:6], 6'b0}, l1i_addr);
        outst = 1;
        req_addr = l1i_addr;
      end
      dropped = 0;
      if (l1i_valid) begin
        if (drop_pend) begin
          drop_pend = 0;
          dropped = 1;   // stale line, no fill
        end else begin
          m_val[set_of(req_addr)]  = 1'b1;
          m_tag[set_of(req_addr)]  = req_addr[63:6];
          m_line[set_of(req_addr)] = l1i_line;
        end
        outst = 0;
      end
      if (res_pend) train(res_pc, res_taken);  // visible one cycle late
      res_pend = x_bcond_resolved;
      res_pc = x_pc;
      res_taken = x_taken;
      redir_q = x_pc_incorrect;
      if (x_pc_incorrect) begin
        if (outst) drop_pend = 1;
        exp_pc = x_pc + {{45{x_correction_offset[18]}}, x_correction_offset};
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_branch_pred.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_branch_pred;

  localparam int NUM_TESTS   = 5;
  localparam int TEST_CYCLES = 400;
  localparam int GHR_BITS    = 8;
  localparam int PC_BITS     = 8;

  logic                      clk_in;
  logic                      rst_N_in;
  logic                      l1i_valid;
  logic [bp_pkg::LINE_W-1:0] l1i_line;
  logic                      x_bcond_resolved;
  logic                      x_taken;
  logic                      x_pc_incorrect;
  logic [bp_pkg::PC_W-1:0]   x_pc;
  logic [18:0]               x_correction_offset;
  logic                      l1i_req;
  logic [bp_pkg::PC_W-1:0]   l1i_addr;
  logic                      pc_valid_out;
  logic [bp_pkg::PC_W-1:0]   fetch_pc;
  logic [bp_pkg::LINE_W-1:0] fetch_line;
  logic [bp_pkg::PC_W-1:0]   pred_pc;
  logic                      br_valid;
  logic [1:0]                br_slot;
  bp_pkg::br_kind_e          br_kind;
  logic [bp_pkg::PC_W-1:0]   br_target;
  logic                      br_taken;
  logic                      l0_next_hit;

  logic [31:0] test_idx;
  logic [31:0] total_errors;
  logic [31:0] total_windows;
  logic [31:0] errors;
  int          phase;          // selects the instruction mix of new words
  logic [31:0] mem [logic [63:0]];  // instruction words by byte address
  logic [63:0] cond_q [$];     // fetched b.cond pcs waiting for resolution

  always #20 clk_in = ~clk_in;

  // random instruction word whose branch targets stay inside the 4 KB block
  function automatic logic [31:0] make_word(input logic [63:0] addr);
    logic [63:0] tgt;
    logic [63:0] d;
    int          k;
    tgt = {addr[63:12], 12'h0} + (64'($urandom_range(1023)) << 2);
    d   = (tgt - addr) >> 2;  // only the low immediate bits are used
    if (phase == 1 || $urandom_range(99) < 70) begin
      return 32'h9000_0000 | ($urandom & 32'h03ff_ffff);  // never matches a branch
    end
    if (phase == 2) k = $urandom_range(2);                 // b, bl, ret
    else if (phase == 3) k = ($urandom_range(4) == 0) ? 0 : 3;  // mostly b.cond
    else k = $urandom_range(3);
    case (k)
      0: return {bp_pkg::OPC_B, d[25:0]};
      1: return {bp_pkg::OPC_BL, d[25:0]};
      2: return 32'hd65f03c0;  // ret x30
      default: return {bp_pkg::OPC_BCOND, d[18:0], 1'b0, 4'($urandom)};
    endcase
  endfunction

  function automatic logic [bp_pkg::LINE_W-1:0] build_line(input logic [63:0] base);
    logic [bp_pkg::LINE_W-1:0] ln;
    logic [63:0]               a;
    for (int i = 0; i < 16; i++) begin
      a = base + 64'(4 * i);
      if (!mem.exists(a)) mem[a] = make_word(a);  // filled on first touch
      ln[32*i +: 32] = mem[a];
    end
    return ln;
  endfunction

  // redirect somewhere inside the region of test p
  task automatic drive_redirect(input int p);
    logic [63:0] tgt;
    logic [18:0] off;
    tgt = (64'(p) << 16) + (64'($urandom_range(1023)) << 2);
    off = 19'($urandom) & 19'h7fffc;
    x_pc                = tgt - {{45{off[18]}}, off};
    x_correction_offset = off;
    x_pc_incorrect      = 1'b1;
  endtask

  task automatic drive_resolve();
    logic [63:0] pc;
    pc = cond_q.pop_front();
    x_pc             = pc;
    x_taken          = pc[3] ? ($urandom_range(99) < 15) : ($urandom_range(99) < 90);
    x_bcond_resolved = 1'b1;
  endtask

  // l1 responder answering one request at a time after 1 to 6 cycles
  initial begin
    int          lat;
    logic [63:0] addr;
    forever begin
      @(posedge clk_in);
      if (l1i_req && !rst_N_in) begin
        lat  = $urandom_range(6, 1);
        addr = l1i_addr;
        repeat (lat - 1) @(posedge clk_in);
        #2;
        l1i_line  = build_line(addr);
        l1i_valid = 1'b1;
        @(posedge clk_in);
        #2 l1i_valid = 1'b0;
      end
    end
  end

  initial begin
    clk_in = 1'b0;
    rst_N_in = 1'b1;
    l1i_valid = 1'b0;
    l1i_line = '0;
    x_bcond_resolved = 1'b0;
    x_taken = 1'b0;
    x_pc_incorrect = 1'b0;
    x_pc = '0;
    x_correction_offset = '0;
    test_idx = 0;
    phase = 1;
    void'($urandom(32'h7b2d));
    repeat (5) @(posedge clk_in);
    #2 rst_N_in = 1'b0;
    for (int p = 1; p <= NUM_TESTS; p++) begin
      phase    = p;
      test_idx = p;
      for (int c = 0; c < TEST_CYCLES; c++) begin
        @(posedge clk_in);
        #2;
        x_bcond_resolved = 1'b0;
        x_pc_incorrect   = 1'b0;
        if (pc_valid_out && br_valid && br_kind == bp_pkg::BR_COND && cond_q.size() < 16)
          cond_q.push_back(fetch_pc + {br_slot, 2'b00});
        if (c == 0 || $urandom_range(999) < ((p == 5) ? 80 : (p == 1) ? 0 : 10))
          drive_redirect(p);  // first cycle moves fetch into the test's region
        else if (cond_q.size() > 0 && $urandom_range(99) < ((p == 3) ? 60 : 15))
          drive_resolve();
      end
    end
    @(posedge clk_in);
    #2;
    x_bcond_resolved = 1'b0;
    x_pc_incorrect   = 1'b0;
    test_idx         = NUM_TESTS + 1;  // closes the last test line
    repeat (2) @(posedge clk_in);
    #2;
    errors = total_errors + u_branch_pred.u_bp_assert.fail_count;
    $display("summary: %0d tests, %0d windows, %0d errors", NUM_TESTS, total_windows, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(NUM_TESTS * TEST_CYCLES * 8 * 40);
    $display("run hung: watchdog expired before all tests completed");
    $display("Test failures found");
    $finish;
  end

  branch_pred #(
    .L0_SETS(8), .RAS_DEPTH(8), .GHR_BITS(GHR_BITS), .PC_BITS(PC_BITS)
  ) u_branch_pred (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .l1i_valid(l1i_valid), .l1i_line(l1i_line),
    .x_bcond_resolved(x_bcond_resolved), .x_taken(x_taken),
    .x_pc_incorrect(x_pc_incorrect), .x_pc(x_pc), .x_correction_offset(x_correction_offset),
    .l1i_req(l1i_req), .l1i_addr(l1i_addr), .pc_valid_out(pc_valid_out),
    .fetch_pc(fetch_pc), .fetch_line(fetch_line), .pred_pc(pred_pc),
    .br_valid(br_valid), .br_slot(br_slot), .br_kind(br_kind), .br_target(br_target),
    .br_taken(br_taken), .l0_next_hit(l0_next_hit)
  );

  bp_checker #(
    .L0_SETS(8), .RAS_DEPTH(8), .GHR_BITS(GHR_BITS), .PC_BITS(PC_BITS)
  ) u_checker (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .test_idx(test_idx),
    .l1i_req(l1i_req), .l1i_addr(l1i_addr), .l1i_valid(l1i_valid), .l1i_line(l1i_line),
    .x_bcond_resolved(x_bcond_resolved), .x_taken(x_taken),
    .x_pc_incorrect(x_pc_incorrect), .x_pc(x_pc), .x_correction_offset(x_correction_offset),
    .pc_valid_out(pc_valid_out), .fetch_pc(fetch_pc), .fetch_line(fetch_line),
    .pred_pc(pred_pc), .br_valid(br_valid), .br_slot(br_slot), .br_kind(br_kind),
    .br_target(br_target), .br_taken(br_taken), .l0_next_hit(l0_next_hit),
    .total_errors(total_errors), .total_windows(total_windows)
  );

  bind branch_pred bp_assert u_bp_assert (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .l1i_req(l1i_req), .l1i_valid(l1i_valid),
    .pc_valid_out(pc_valid_out), .br_valid(br_valid), .br_slot(br_slot),
    .fetch_pc(fetch_pc)
  );

endmodule

`default_nettype wire

// ==== src.f ====
hw/bp_pkg.sv
hw/return_stack.sv
hw/gshare_pht.sv
hw/l0_icache.sv
hw/predecode.sv
hw/branch_pred.sv
verification/bp_assert.sv
verification/bp_checker.sv
verification/tb_branch_pred.sv

// ==== Bender.yml ====
package:
  name: branch_pred

sources:
  - files:
      - hw/bp_pkg.sv
      - hw/return_stack.sv
      - hw/gshare_pht.sv
      - hw/l0_icache.sv
      - hw/predecode.sv
      - hw/branch_pred.sv
  - target: test
    files:
      - verification/bp_assert.sv
      - verification/bp_checker.sv
      - verification/tb_branch_pred.sv
